// File: src/sysctl_pkg.sv
//////////////////////////////////////////////////////////////
// sysctl_pkg
// address map, widths, reset length and enums shared by the
// system control and status subsystem
//////////////////////////////////////////////////////////////

package sysctl_pkg;

  // word address map of the Wishbone slave
  localparam int ADR_W = 2;
  localparam logic [ADR_W-1:0] ADR_SCS = 2'd0;  // control and status
  localparam logic [ADR_W-1:0] ADR_ERR = 2'd1;  // error address and number
  localparam logic [ADR_W-1:0] ADR_WDG = 2'd2;  // watchdog

  localparam int PID_W = 5;   // process id
  localparam int PC_W  = 24;  // program counter
  localparam int ERR_W = 8;   // bit 0 watchdog and 7..1 external

  localparam logic [7:0] ERR_NO_BASE = 8'd8;  // error number of signal 0

  localparam int WDG_W = 16;  // watchdog counter

  localparam int RST_HOLD = 4;                 // sys_rst cycles per soft request
  localparam int HOLD_W   = $clog2(RST_HOLD);  // hold counter width

  // decoded bus target
  typedef enum logic [1:0] {
    SEL_SCS,
    SEL_ERR,
    SEL_WDG,
    SEL_NONE
  } reg_sel_e;

  // reset sequencer states
  typedef enum logic {
    RS_IDLE,
    RS_HOLD
  } rst_state_e;

endpackage

// File: src/bus_slave_decoder.sv
//////////////////////////////////////////////////////////////
// bus_slave_decoder
// Wishbone classic slave front end with address decode,
// write strobes, read mux and registered ack
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bus_slave_decoder (
  input  logic                        clk,
  input  logic                        rst_trig,
  input  logic                        cyc,
  input  logic                        stb,
  input  logic                        we,
  input  logic [sysctl_pkg::ADR_W-1:0] adr,
  input  logic [31:0]                 scs_view,
  input  logic [31:0]                 err_view,
  input  logic [31:0]                 wdg_view,
  output logic                        ack,
  output logic [31:0]                 dat_r,
  output logic                        scs_wr,
  output logic                        err_wr,
  output logic                        wdg_wr
);

  sysctl_pkg::reg_sel_e sel;
  logic                 req_new;  // first cycle of a request

  always_comb begin
    case (adr)
      sysctl_pkg::ADR_SCS: sel = sysctl_pkg::SEL_SCS;
      sysctl_pkg::ADR_ERR: sel = sysctl_pkg::SEL_ERR;
      sysctl_pkg::ADR_WDG: sel = sysctl_pkg::SEL_WDG;
      default:             sel = sysctl_pkg::SEL_NONE;  // address 3 unmapped
    endcase
  end

  assign req_new = cyc & stb & ~ack;

  assign scs_wr = req_new & we & (sel == sysctl_pkg::SEL_SCS);
  assign err_wr = req_new & we & (sel == sysctl_pkg::SEL_ERR);
  assign wdg_wr = req_new & we & (sel == sysctl_pkg::SEL_WDG);

  always_ff @(posedge clk) begin
    if (!rst_trig) begin
      ack <= 1'b0;
    end else begin
      ack <= req_new;  // one cycle after the request
    end
  end

  always_ff @(posedge clk) begin
    if (req_new) begin
      case (sel)
        sysctl_pkg::SEL_SCS: dat_r <= scs_view;
        sysctl_pkg::SEL_ERR: dat_r <= err_view;
        sysctl_pkg::SEL_WDG: dat_r <= wdg_view;
        default:             dat_r <= 32'b0;
      endcase
    end
  end

  // a held strobe gets a single ack per request
  a_ack_single : assert property (
    @(posedge clk) disable iff (!rst_trig)
    (ack && stb) |=> !(ack && stb)
  );

endmodule

// File: src/sys_ctrl_status.sv
//////////////////////////////////////////////////////////////
// sys_ctrl_status
// control and status registers, first-error capture with
// program counter and error number, soft reset request
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_ctrl_status (
  input  logic                         clk,
  input  logic                         rst_trig,
  input  logic                         scs_wr,
  input  logic                         err_wr,
  input  logic [31:0]                  dat_w,
  input  logic [sysctl_pkg::ERR_W-1:0] err_sig,
  input  logic [sysctl_pkg::PC_W-1:0]  err_addr,
  output logic [31:0]                  scs_view,
  output logic [31:0]                  err_view,
  output logic [sysctl_pkg::PID_W-1:0] cp_pid,
  output logic                         sw_rst_req
);

  localparam int PID_W = sysctl_pkg::PID_W;
  localparam int IDX_W = $clog2(sysctl_pkg::ERR_W);

  logic [7:0]                  scs;         // status byte with bit 1 resetting
  logic [PID_W-1:0]            cp_pid_r;    // current process
  logic [PID_W-1:0]            err_pid_r;   // process at error
  logic [sysctl_pkg::PC_W-1:0] err_addr_r;
  logic [7:0]                  err_no_r;
  sysctl_pkg::reg_sel_e        wr_sel;      // which register is written
  logic                        err_hit;
  logic [IDX_W-1:0]            err_idx;     // highest set error signal
  logic                        resetting;

  assign resetting = scs[1];

  always_comb begin
    if (scs_wr) begin
      wr_sel = sysctl_pkg::SEL_SCS;
    end else if (err_wr) begin
      wr_sel = sysctl_pkg::SEL_ERR;
    end else begin
      wr_sel = sysctl_pkg::SEL_NONE;
    end
  end

  // priority encoder where a later index overrides
  always_comb begin
    err_hit = 1'b0;
    err_idx = '0;
    for (int i = 0; i < sysctl_pkg::ERR_W; i++) begin
      if (err_sig[i]) begin
        err_hit = 1'b1;
        err_idx = IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_trig) begin
      scs        <= 8'b0;
      cp_pid_r   <= '0;
      err_pid_r  <= '0;
      err_addr_r <= '0;
      err_no_r   <= 8'b0;
      sw_rst_req <= 1'b0;
    end else if (resetting) begin
      sw_rst_req <= 1'b1;  // one-cycle request
      scs[1]     <= 1'b0;
    end else begin
      sw_rst_req <= 1'b0;
      case (wr_sel)
        sysctl_pkg::SEL_SCS: begin
          scs       <= dat_w[7:0];
          cp_pid_r  <= dat_w[12:8];
          err_pid_r <= dat_w[17:13];
        end
        sysctl_pkg::SEL_ERR: begin
          {err_addr_r, err_no_r} <= dat_w;
        end
        default: begin
          if (err_hit) begin  // a write in the same cycle wins
            scs[1]     <= 1'b1;
            err_addr_r <= err_addr;
            err_no_r   <= sysctl_pkg::ERR_NO_BASE + {{(8-IDX_W){1'b0}}, err_idx};
          end
        end
      endcase
    end
  end

  assign scs_view = {{(32 - 2*PID_W - 8){1'b0}}, err_pid_r, cp_pid_r, scs};
  assign err_view = {err_addr_r, err_no_r};
  assign cp_pid   = cp_pid_r;

  a_req_pulse : assert property (
    @(posedge clk) disable iff (!rst_trig)
    sw_rst_req |=> !sw_rst_req
  );

  // decoder issues at most one strobe per request
  a_wr_excl : assert property (
    @(posedge clk) disable iff (!rst_trig)
    !(scs_wr && err_wr)
  );

endmodule

// File: src/watchdog.sv
//////////////////////////////////////////////////////////////
// watchdog
// software-reloaded down counter, flags a one-cycle timeout
// error and disables itself when it runs out
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module watchdog (
  input  logic        clk,
  input  logic        sys_rst,
  input  logic        wdg_wr,
  input  logic [31:0] dat_w,
  output logic [31:0] wdg_view,
  output logic        wdg_timeout
);

  localparam int WDG_W = sysctl_pkg::WDG_W;

  logic             en;
  logic [WDG_W-1:0] reload;  // last written value
  logic [WDG_W-1:0] count;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      en          <= 1'b0;
      reload      <= '0;
      count       <= '0;
      wdg_timeout <= 1'b0;
    end else begin
      wdg_timeout <= 1'b0;
      if (wdg_wr) begin  // kick or reprogram
        reload <= dat_w[WDG_W-1:0];
        count  <= dat_w[WDG_W-1:0];
        en     <= |dat_w[WDG_W-1:0];  // zero disables
      end else if (en) begin
        count <= count - 1'b1;
        if (count == WDG_W'(1)) begin
          wdg_timeout <= 1'b1;
          en          <= 1'b0;
        end
      end
    end
  end

  assign wdg_view = {en, {(31 - WDG_W){1'b0}}, count};

  a_count_le_reload : assert property (
    @(posedge clk) disable iff (sys_rst)
    count <= reload
  );

endmodule

// File: src/reset_sequencer.sv
//////////////////////////////////////////////////////////////
// reset_sequencer
// merges external and soft reset, holds sys_rst for a
// fixed number of cycles after a soft request
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reset_sequencer (
  input  logic clk,
  input  logic rst_trig,
  input  logic sw_rst_req,
  output logic sys_rst
);

  localparam int HOLD_W = sysctl_pkg::HOLD_W;

  sysctl_pkg::rst_state_e state;
  logic [HOLD_W-1:0]      hold_cnt;  // cycles spent in hold

  always_ff @(posedge clk) begin
    if (!rst_trig) begin
      state    <= sysctl_pkg::RS_IDLE;
      hold_cnt <= '0;
    end else begin
      case (state)
        sysctl_pkg::RS_IDLE: begin
          if (sw_rst_req) begin
            state    <= sysctl_pkg::RS_HOLD;
            hold_cnt <= '0;
          end
        end
        sysctl_pkg::RS_HOLD: begin
          if (sw_rst_req) begin
            hold_cnt <= '0;  // late request restarts the hold
          end else if (hold_cnt == HOLD_W'(sysctl_pkg::RST_HOLD - 1)) begin
            state <= sysctl_pkg::RS_IDLE;
          end else begin
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        default: state <= sysctl_pkg::RS_IDLE;
      endcase
    end
  end

  assign sys_rst = !rst_trig || (state == sysctl_pkg::RS_HOLD);

endmodule

// File: src/sysctl_top.sv
//////////////////////////////////////////////////////////////
// sysctl_top
// system control subsystem: bus decoder, control and status
// registers, watchdog and reset sequencer
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sysctl_top (
  input  logic                         clk,
  input  logic                         rst_trig,
  input  logic                         cyc,
  input  logic                         stb,
  input  logic                         we,
  input  logic [sysctl_pkg::ADR_W-1:0] adr,
  input  logic [31:0]                  dat_w,
  input  logic [6:0]                   err_ext,   // error sources 7..1
  input  logic [sysctl_pkg::PC_W-1:0]  err_addr,  // program counter
  output logic                         ack,
  output logic [31:0]                  dat_r,
  output logic                         sys_rst,
  output logic [sysctl_pkg::PID_W-1:0] cp_pid
);

  logic [31:0]                  scs_view;
  logic [31:0]                  err_view;
  logic [31:0]                  wdg_view;
  logic                         scs_wr;
  logic                         err_wr;
  logic                         wdg_wr;
  logic                         wdg_timeout;
  logic                         sw_rst_req;
  logic [sysctl_pkg::ERR_W-1:0] err_sig;

  assign err_sig = {err_ext, wdg_timeout};  // watchdog is source 0

  bus_slave_decoder u_dec (
    .clk      (clk),
    .rst_trig (rst_trig),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .adr      (adr),
    .scs_view (scs_view),
    .err_view (err_view),
    .wdg_view (wdg_view),
    .ack      (ack),
    .dat_r    (dat_r),
    .scs_wr   (scs_wr),
    .err_wr   (err_wr),
    .wdg_wr   (wdg_wr)
  );

  sys_ctrl_status u_scs (
    .clk        (clk),
    .rst_trig   (rst_trig),
    .scs_wr     (scs_wr),
    .err_wr     (err_wr),
    .dat_w      (dat_w),
    .err_sig    (err_sig),
    .err_addr   (err_addr),
    .scs_view   (scs_view),
    .err_view   (err_view),
    .cp_pid     (cp_pid),
    .sw_rst_req (sw_rst_req)
  );

  watchdog u_wdg (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .wdg_wr      (wdg_wr),
    .dat_w       (dat_w),
    .wdg_view    (wdg_view),
    .wdg_timeout (wdg_timeout)
  );

  reset_sequencer u_rst (
    .clk        (clk),
    .rst_trig   (rst_trig),
    .sw_rst_req (sw_rst_req),
    .sys_rst    (sys_rst)
  );

endmodule

// File: verification/sysctl_tb.sv
//////////////////////////////////////////////////////////////
// sysctl_tb
// table-driven testbench for the system control subsystem
// covering register access, error capture, soft reset and watchdog
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sysctl_tb;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_ERR, OP_RST, OP_KICK} op_e;

  typedef struct packed {
    op_e         op;
    logic [1:0]  adr;
    logic [31:0] data;
    logic [31:0] mask;      // bits compared on a read
    logic [31:0] exp;
    logic        use_addr;  // expect current err_addr in bits 31..8
    logic [6:0]  err;
    logic [4:0]  pid;
    logic [7:0]  n;         // wait limit or kick count
  } row_t;

  localparam logic [1:0]  A_SCS = sysctl_pkg::ADR_SCS;
  localparam logic [1:0]  A_ERR = sysctl_pkg::ADR_ERR;
  localparam logic [1:0]  A_WDG = sysctl_pkg::ADR_WDG;
  localparam logic [31:0] NO_BASE = 32'(sysctl_pkg::ERR_NO_BASE);
  localparam logic [31:0] M_ALL = 32'hffff_ffff;
  localparam int ACK_MAX  = 8;
  localparam int ROW_CYC  = 80;  // longest row with five kicks
  localparam int WDG_WAIT = 64;

  logic        clk;
  logic        rst_trig;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [1:0]  adr;
  logic [31:0] dat_w;
  logic [6:0]  err_ext;
  logic [23:0] err_addr;
  logic        ack;
  logic [31:0] dat_r;
  logic        sys_rst;
  logic [4:0]  cp_pid;

  row_t   rows[$];
  int     errors = 0;
  int     checks = 0;
  integer seed = 32'h8707_ec81;

  sysctl_top UUT (.clk(clk), .rst_trig(rst_trig), .cyc(cyc), .stb(stb), .we(we),
    .adr(adr), .dat_w(dat_w), .err_ext(err_ext), .err_addr(err_addr), .ack(ack),
    .dat_r(dat_r), .sys_rst(sys_rst), .cp_pid(cp_pid));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic add_row(input op_e op, input logic [1:0] a, input logic [31:0] d,
                         input logic [31:0] m, input logic [31:0] e, input logic ua,
                         input logic [6:0] er, input logic [4:0] p, input logic [7:0] n);
    rows.push_back('{op, a, d, m, e, ua, er, p, n});
  endtask

  // one Wishbone classic access held until ack
  task automatic bus_access(input logic wr, input logic [1:0] a, input logic [31:0] d,
                            output logic [31:0] q);
    int n;
    n = 0;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= wr;
    adr   <= a;
    dat_w <= d;
    @(negedge clk);
    while (!ack && n < ACK_MAX) begin
      n++;
      @(negedge clk);
    end
    if (!ack) begin
      $display("no ack from the DUT within %0d cycles at %0t", ACK_MAX, $time);
      errors++;
    end
    q = dat_r;
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  // waits for sys_rst to rise and measures how long it stays high
  task automatic wait_reset_pulse(input int limit);
    int waited;
    int high;
    waited = 0;
    high   = 0;
    @(negedge clk);
    while (!sys_rst && waited < limit) begin
      waited++;
      @(negedge clk);
    end
    if (!sys_rst) begin
      $display("sys_rst did not rise within %0d cycles at %0t", limit, $time);
      errors++;
    end else begin
      while (sys_rst && high < 4 * sysctl_pkg::RST_HOLD) begin
        high++;
        @(negedge clk);
      end
      checks++;
      if (high != sysctl_pkg::RST_HOLD) begin
        $display("Fail t=%0t sys_rst high cycles expected %0d got %0d", $time,
                 sysctl_pkg::RST_HOLD, high);
        errors++;
      end
    end
  endtask

  initial begin
    row_t        r;
    logic [31:0] rd;
    logic [31:0] exp;
    rst_trig = 1'b0;
    cyc      = 1'b0;
    stb      = 1'b0;
    we       = 1'b0;
    adr      = 2'd0;
    dat_w    = 32'h0;
    err_ext  = 7'h0;
    err_addr = 24'h0;
    // everything reads zero after reset
    add_row(OP_RD, A_SCS, 32'h0, M_ALL, 32'h0, 1'b0, 7'h00, 5'h00, 8'd0);
    add_row(OP_RD, A_ERR, 32'h0, M_ALL, 32'h0, 1'b0, 7'h00, 5'h00, 8'd0);
    add_row(OP_RD, A_WDG, 32'h0, M_ALL, 32'h0, 1'b0, 7'h00, 5'h00, 8'd0);
    add_row(OP_RD, 2'd3, 32'h0, M_ALL, 32'h0, 1'b0, 7'h00, 5'h00, 8'd0);
    add_row(OP_WR, A_SCS, 32'hfff3_5a75, M_ALL, 32'h0, 1'b0, 7'h00, 5'h1a, 8'd0);
    add_row(OP_RD, A_SCS, 32'h0, M_ALL, 32'h0003_5a75, 1'b0, 7'h00, 5'h1a, 8'd0);
    add_row(OP_WR, A_ERR, 32'hdead_be07, M_ALL, 32'h0, 1'b0, 7'h00, 5'h1a, 8'd0);
    add_row(OP_RD, A_ERR, 32'h0, M_ALL, 32'hdead_be07, 1'b0, 7'h00, 5'h1a, 8'd0);
    add_row(OP_RD, 2'd3, 32'h0, M_ALL, 32'h0, 1'b0, 7'h00, 5'h1a, 8'd0);
    // err_ext bits 1 and 4 so index 5 wins
    add_row(OP_ERR, A_SCS, 32'h0, M_ALL, 32'h0, 1'b0, 7'h12, 5'h1a, 8'd0);
    add_row(OP_RST, A_SCS, 32'h0, M_ALL, 32'h0, 1'b0, 7'h00, 5'h1a, 8'd8);
    add_row(OP_RD, A_ERR, 32'h0, M_ALL, NO_BASE + 32'd5, 1'b1, 7'h00, 5'h1a, 8'd0);
    add_row(OP_RD, A_SCS, 32'h0, M_ALL, 32'h0003_5a75, 1'b0, 7'h00, 5'h1a, 8'd0);
    // software reset through status bit 1
    add_row(OP_WR, A_SCS, 32'h0003_5a77, M_ALL, 32'h0, 1'b0, 7'h00, 5'h1a, 8'd0);
    add_row(OP_RST, A_SCS, 32'h0, M_ALL, 32'h0, 1'b0, 7'h00, 5'h1a, 8'd8);
    add_row(OP_RD, A_ERR, 32'h0, M_ALL, NO_BASE + 32'd5, 1'b1, 7'h00, 5'h1a, 8'd0);
    add_row(OP_RD, A_SCS, 32'h0, M_ALL, 32'h0003_5a75, 1'b0, 7'h00, 5'h1a, 8'd0);
    // err_ext bits 0 and 6 so index 7 wins
    add_row(OP_ERR, A_SCS, 32'h0, M_ALL, 32'h0, 1'b0, 7'h41, 5'h1a, 8'd0);
    add_row(OP_RST, A_SCS, 32'h0, M_ALL, 32'h0, 1'b0, 7'h00, 5'h1a, 8'd8);
    add_row(OP_RD, A_ERR, 32'h0, M_ALL, NO_BASE + 32'd7, 1'b1, 7'h00, 5'h1a, 8'd0);
    // watchdog with a new err_addr and reload 20, five kicks before it expires
    add_row(OP_ERR, A_SCS, 32'h0, M_ALL, 32'h0, 1'b0, 7'h00, 5'h1a, 8'd0);
    add_row(OP_WR, A_WDG, 32'd20, M_ALL, 32'h0, 1'b0, 7'h00, 5'h1a, 8'd0);
    add_row(OP_RD, A_WDG, 32'h0, 32'hffff_0000, 32'h8000_0000, 1'b0, 7'h00, 5'h1a, 8'd0);
    add_row(OP_KICK, A_WDG, 32'd20, M_ALL, 32'h0, 1'b0, 7'h00, 5'h1a, 8'd5);
    // reload plus 4 less the two cycles that end the last kick
    add_row(OP_RST, A_SCS, 32'h0, M_ALL, 32'h0, 1'b0, 7'h00, 5'h1a, 8'd22);
    add_row(OP_RD, A_ERR, 32'h0, M_ALL, NO_BASE, 1'b1, 7'h00, 5'h1a, 8'd0);
    add_row(OP_RD, A_WDG, 32'h0, M_ALL, 32'h0, 1'b0, 7'h00, 5'h1a, 8'd0);
    add_row(OP_RD, A_SCS, 32'h0, M_ALL, 32'h0003_5a75, 1'b0, 7'h00, 5'h1a, 8'd0);

    repeat (5) begin
      @(negedge clk);
      checks++;
      if (sys_rst !== 1'b1) begin
        $display("Fail t=%0t sys_rst expected 1 got %b", $time, sys_rst);
        errors++;
      end
      checks++;
      if (ack !== 1'b0) begin
        $display("Fail t=%0t ack expected 0 got %b", $time, ack);
        errors++;
      end
    end
    @(posedge clk);
    rst_trig <= 1'b1;
    @(negedge clk);
    checks++;
    if (sys_rst !== 1'b0) begin
      $display("Fail t=%0t sys_rst expected 0 got %b", $time, sys_rst);
      errors++;
    end

    foreach (rows[i]) begin
      r = rows[i];
      case (r.op)
        OP_WR: bus_access(1'b1, r.adr, r.data, rd);
        OP_RD: begin
          bus_access(1'b0, r.adr, 32'h0, rd);
          exp = r.use_addr ? {err_addr, r.exp[7:0]} : r.exp;
          checks++;
          if ((rd & r.mask) !== (exp & r.mask)) begin
            $display("Fail t=%0t dat_r row %0d expected %h got %h", $time, i,
                     exp & r.mask, rd & r.mask);
            errors++;
          end
        end
        OP_ERR: begin
          @(posedge clk);
          err_ext  <= r.err;
          err_addr <= 24'($random(seed));
          @(posedge clk);
          err_ext  <= 7'h0;  // one-cycle error pulse
        end
        OP_RST: wait_reset_pulse(r.n);
        OP_KICK: begin
          repeat (r.n) begin
            repeat (8) begin
              @(negedge clk);
              checks++;
              if (sys_rst) begin
                $display("Fail t=%0t sys_rst expected 0 got 1", $time);
                errors++;
              end
            end
            bus_access(1'b1, A_WDG, r.data, rd);
          end
        end
        default: $display("unknown operation in row %0d", i);
      endcase
      @(negedge clk);
      checks++;
      if (cp_pid !== r.pid) begin
        $display("Fail t=%0t cp_pid row %0d expected %h got %h", $time, i, r.pid, cp_pid);
        errors++;
      end
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // run limit from table length plus the longest watchdog wait
  initial begin
    longint limit_ns;
    #1;
    limit_ns = (longint'(rows.size()) * ROW_CYC + WDG_WAIT + 10) * 10;
    #(limit_ns);
    $display("run did not finish within %0d ns", limit_ns);
    $display("tests failed");
    $finish;
  end

endmodule

// File: sysctl_top.f
src/sysctl_pkg.sv
src/bus_slave_decoder.sv
src/sys_ctrl_status.sv
src/watchdog.sv
src/reset_sequencer.sv
src/sysctl_top.sv
verification/sysctl_tb.sv

// File: Bender.yml
package:
  name: sysctl

sources:
  - src/sysctl_pkg.sv
  - src/bus_slave_decoder.sv
  - src/sys_ctrl_status.sv
  - src/watchdog.sv
  - src/reset_sequencer.sv
  - src/sysctl_top.sv
  - target: simulation
    files:
      - verification/sysctl_tb.sv
